// File: common/regs_pkg.sv
`default_nettype none

package regs_pkg;

  // ---------------------------------------------------------
  // widths and sizes
  localparam int WORD_W         = 32;              // bus and data word
  localparam int ADDR_DEC_W     = 20;              // decoded address bits
  localparam int FIFO_DEPTH     = 512;             // push fifo entries
  localparam int FIFO_CNT_W     = 10;              // holds 0 .. 512
  localparam int FIFO_AFULL_LVL = FIFO_DEPTH - 1;  // one slot left
  localparam int BLOCK_WORDS    = 16;              // words per 512 bit block
  localparam int ROUNDS         = 64;
  localparam int HASH_WORDS     = 8;

  typedef logic [HASH_WORDS*WORD_W-1:0] hash_t;    // H0 in the top word

  localparam logic [WORD_W-1:0] CURRENT_DATE = 32'h24010101;  // yymmddss

  // ---------------------------------------------------------
  // register map, byte offsets
  localparam logic [ADDR_DEC_W-1:0] ADR_CTRL        = 20'h00000;
  localparam logic [ADDR_DEC_W-1:0] ADR_STATUS      = 20'h00004;
  localparam logic [ADDR_DEC_W-1:0] ADR_VERSION     = 20'h0000C;
  localparam logic [ADDR_DEC_W-1:0] ADR_SHA_CTRL    = 20'h00100;
  localparam logic [ADDR_DEC_W-1:0] ADR_SHA_STATUS  = 20'h00104;
  localparam logic [ADDR_DEC_W-1:0] ADR_SHA_PUSH    = 20'h0010C;  // write only
  localparam logic [ADDR_DEC_W-1:0] ADR_SHA_HASH_H7 = 20'h00110;  // H0 sits at 0x12c
  localparam logic [ADDR_DEC_W-1:0] ADR_SHA_FILL    = 20'h00130;

  // bit positions
  localparam int CTRL_ENABLE     = 0;
  localparam int SHA_CTRL_ENABLE = 0;
  localparam int SHA_CTRL_RESET  = 1;   // one-shot
  localparam int STAT_X11_ACT    = 0;
  localparam int STAT_SHA_ACT    = 4;
  localparam int SHA_ST_READY    = 0;
  localparam int SHA_ST_VALID    = 1;
  localparam int SHA_ST_EMPTY    = 4;
  localparam int SHA_ST_AFULL    = 5;
  localparam int SHA_ST_FULL     = 6;

  // engine phases
  localparam logic [1:0] PH_IDLE  = 2'd0;
  localparam logic [1:0] PH_LOAD  = 2'd1;
  localparam logic [1:0] PH_ROUND = 2'd2;
  localparam logic [1:0] PH_ADD   = 2'd3;

  // ---------------------------------------------------------
  // sha-256 constants
  localparam hash_t sha_iv = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                              32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

  localparam logic [WORD_W-1:0] sha_k [0:ROUNDS-1] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // rotate right, shared by schedule and round logic
  function automatic logic [WORD_W-1:0] ror(input logic [WORD_W-1:0] x, input int n);
    return (x >> n) | (x << (WORD_W - n));
  endfunction

endpackage

`default_nettype wire

// File: design/bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bus_regs import regs_pkg::*; (
  input  logic                  clk_125mhz,
  input  logic                  rstn_125mhz,
  input  logic [WORD_W-1:0]     sys_addr_i,
  input  logic [WORD_W-1:0]     sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  input  logic [FIFO_CNT_W-1:0] fifo_count_i,
  input  logic                  fifo_empty_i,
  input  logic                  fifo_afull_i,
  input  logic                  fifo_full_i,
  input  logic                  sha_ready_i,
  input  logic                  sha_valid_i,
  input  hash_t                 hash_words_i,
  output logic [WORD_W-1:0]     sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  x11_activated_o,
  output logic                  sha_rstn_o,
  output logic                  push_o,
  output logic [WORD_W-1:0]     push_data_o
);

  logic [ADDR_DEC_W-1:0] adr;
  logic [ADDR_DEC_W-1:0] hoff;             // offset into the hash window
  logic [WORD_W-1:0]     ctrl_q;
  logic [WORD_W-1:0]     sha_ctrl_q;
  logic [WORD_W-1:0]     status_w;
  logic [WORD_W-1:0]     sha_status_w;
  logic [WORD_W-1:0]     rd_word;

  assign adr  = sys_addr_i[ADDR_DEC_W-1:0];  // upper bits don't care
  assign hoff = adr - ADR_SHA_HASH_H7;

  // ---------------------------------------------------------
  // write decode
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
      push_o     <= 1'b0;
    end else begin
      sha_ctrl_q[SHA_CTRL_RESET] <= 1'b0;  // self clearing
      push_o                     <= 1'b0;
      if (sys_wen_i) begin
        case (adr)
          ADR_CTRL:     ctrl_q     <= sys_wdata_i;
          ADR_SHA_CTRL: sha_ctrl_q <= sys_wdata_i;
          ADR_SHA_PUSH: push_o     <= 1'b1;  // one word into the fifo
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_125mhz) begin
    if (sys_wen_i && adr == ADR_SHA_PUSH)
      push_data_o <= sys_wdata_i;
  end

  // activation, sha part held in reset unless both enables are up
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      x11_activated_o <= 1'b0;
      sha_rstn_o      <= 1'b0;
    end else begin
      x11_activated_o <= ctrl_q[CTRL_ENABLE];
      sha_rstn_o      <= ctrl_q[CTRL_ENABLE] & sha_ctrl_q[SHA_CTRL_ENABLE] &
                         ~sha_ctrl_q[SHA_CTRL_RESET];
    end
  end

  // ---------------------------------------------------------
  // status words
  always_comb begin
    status_w                     = '0;
    status_w[STAT_X11_ACT]       = x11_activated_o;
    status_w[STAT_SHA_ACT]       = sha_rstn_o;
    sha_status_w                 = '0;
    sha_status_w[SHA_ST_READY]   = sha_ready_i;
    sha_status_w[SHA_ST_VALID]   = sha_valid_i;
    sha_status_w[SHA_ST_EMPTY]   = fifo_empty_i & sha_rstn_o;  // idle part reports nothing
    sha_status_w[SHA_ST_AFULL]   = fifo_afull_i;
    sha_status_w[SHA_ST_FULL]    = fifo_full_i;
  end

  // read mux
  always_comb begin
    rd_word = '0;                          // unmapped reads 0
    case (adr)
      ADR_CTRL:       rd_word = ctrl_q;
      ADR_STATUS:     rd_word = status_w;
      ADR_VERSION:    rd_word = CURRENT_DATE;
      ADR_SHA_CTRL: begin
        rd_word                 = sha_ctrl_q;
        rd_word[SHA_CTRL_RESET] = 1'b0;    // one-shot never reads back
      end
      ADR_SHA_STATUS: rd_word = sha_status_w;
      ADR_SHA_FILL:   rd_word = WORD_W'(fifo_count_i);
      default: begin
        // H7 at the low address, H0 at the top
        if (hoff < ADDR_DEC_W'(HASH_WORDS * 4) && hoff[1:0] == 2'b00)
          rd_word = hash_words_i[hoff[4:2]*WORD_W +: WORD_W];
      end
    endcase
  end

  // ---------------------------------------------------------
  // bus response, one cycle after the strobe
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_ren_i)
        sys_rdata_o <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: sha256/word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module word_fifo import regs_pkg::*; (
  input  logic                  clk_125mhz,
  input  logic                  rstn_i,
  input  logic                  push_i,
  input  logic [WORD_W-1:0]     push_data_i,
  input  logic                  pop_i,
  output logic [WORD_W-1:0]     rd_data_o,
  output logic                  rd_vld_o,     // data valid the cycle after a pop
  output logic [FIFO_CNT_W-1:0] count_o,
  output logic                  empty_o,
  output logic                  afull_o,
  output logic                  full_o
);

  logic [WORD_W-1:0]             mem [0:FIFO_DEPTH-1];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;      // wraps at depth
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  logic                          push_ok;
  logic                          pop_ok;

  assign push_ok = push_i & ~full_o;          // push into a full fifo is lost
  assign pop_ok  = pop_i & ~empty_o;

  // flags straight from the count
  assign empty_o = (count_o == '0);
  assign afull_o = (count_o >= FIFO_AFULL_LVL);
  assign full_o  = (count_o == FIFO_DEPTH);

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count_o  <= '0;
      rd_vld_o <= 1'b0;
    end else begin
      wr_ptr   <= wr_ptr + push_ok;
      rd_ptr   <= rd_ptr + pop_ok;
      count_o  <= count_o + FIFO_CNT_W'(push_ok) - FIFO_CNT_W'(pop_ok);
      rd_vld_o <= pop_ok;
    end
  end

  // storage
  always_ff @(posedge clk_125mhz) begin
    if (push_ok)
      mem[wr_ptr] <= push_data_i;
    if (pop_ok)
      rd_data_o <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

// File: sha256/sha256_sched.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_sched import regs_pkg::*; (
  input  logic              clk_125mhz,
  input  logic              rstn_i,
  input  logic              load_i,        // shift in a message word
  input  logic [WORD_W-1:0] load_word_i,
  input  logic              step_i,        // shift in an expanded word
  output logic [WORD_W-1:0] w_o            // word of the current round
);

  logic [WORD_W-1:0] win [0:BLOCK_WORDS-1];  // win[0] is W(t)
  logic [WORD_W-1:0] w_next;

  function automatic logic [WORD_W-1:0] ssig0(input logic [WORD_W-1:0] x);
    return ror(x, 7) ^ ror(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [WORD_W-1:0] ssig1(input logic [WORD_W-1:0] x);
    return ror(x, 17) ^ ror(x, 19) ^ (x >> 10);
  endfunction

  // W(t+16) from W(t+14), W(t+9), W(t+1), W(t)
  assign w_next = ssig1(win[14]) + win[9] + ssig0(win[1]) + win[0];
  assign w_o    = win[0];

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_i) begin
      for (int i = 0; i < BLOCK_WORDS; i++)
        win[i] <= '0;
    end else if (load_i || step_i) begin
      for (int i = 0; i < BLOCK_WORDS-1; i++)
        win[i] <= win[i+1];
      win[BLOCK_WORDS-1] <= load_i ? load_word_i : w_next;
    end
  end

endmodule

`default_nettype wire

// File: sha256/sha256_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_engine import regs_pkg::*; (
  input  logic                  clk_125mhz,
  input  logic                  rstn_i,
  input  logic [FIFO_CNT_W-1:0] fifo_count_i,
  input  logic [WORD_W-1:0]     fifo_data_i,
  input  logic                  fifo_vld_i,
  output logic                  fifo_pop_o,
  output logic                  ready_o,
  output logic                  hash_valid_o,  // level, until the next start
  output hash_t                 hash_o
);

  logic [1:0]        phase;
  logic [6:0]        cnt;                  // pop count in load, round index in round
  logic              start;
  logic              sched_load;
  logic              sched_step;
  logic [WORD_W-1:0] w;
  logic [WORD_W-1:0] va, vb, vc, vd, ve, vf, vg, vh;  // working variables
  logic [WORD_W-1:0] t1, t2;
  hash_t             hash_sum;

  function automatic logic [WORD_W-1:0] bsig0(input logic [WORD_W-1:0] x);
    return ror(x, 2) ^ ror(x, 13) ^ ror(x, 22);
  endfunction

  function automatic logic [WORD_W-1:0] bsig1(input logic [WORD_W-1:0] x);
    return ror(x, 6) ^ ror(x, 11) ^ ror(x, 25);
  endfunction

  assign start      = (phase == PH_IDLE) && ready_o && (fifo_count_i >= BLOCK_WORDS);
  assign fifo_pop_o = (phase == PH_LOAD) && (cnt < BLOCK_WORDS);  // 16 back to back pops
  assign sched_load = (phase == PH_LOAD) && fifo_vld_i;
  assign sched_step = (phase == PH_ROUND);

  sha256_sched i_sha256_sched (
    .clk_125mhz  (clk_125mhz),
    .rstn_i      (rstn_i),
    .load_i      (sched_load),
    .load_word_i (fifo_data_i),
    .step_i      (sched_step),
    .w_o         (w)
  );

  // ---------------------------------------------------------
  // one compression round per cycle
  assign t1 = vh + bsig1(ve) + ((ve & vf) ^ (~ve & vg)) + sha_k[cnt[5:0]] + w;
  assign t2 = bsig0(va) + ((va & vb) ^ (va & vc) ^ (vb & vc));

  always_comb begin
    for (int i = 0; i < HASH_WORDS; i++)
      hash_sum[i*WORD_W +: WORD_W] = hash_o[i*WORD_W +: WORD_W] +
                                     {va, vb, vc, vd, ve, vf, vg, vh}[i*WORD_W +: WORD_W];
  end

  always_ff @(posedge clk_125mhz) begin
    if (start) begin
      {va, vb, vc, vd, ve, vf, vg, vh} <= hash_o;  // chain from current hash
    end else if (phase == PH_ROUND) begin
      {va, vb, vc, vd} <= {t1 + t2, va, vb, vc};
      {ve, vf, vg, vh} <= {vd + t1, ve, vf, vg};
    end
  end

  // ---------------------------------------------------------
  // phase sequencer
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_i) begin
      phase        <= PH_IDLE;
      cnt          <= '0;
      ready_o      <= 1'b0;
      hash_valid_o <= 1'b0;
      hash_o       <= sha_iv;
    end else begin
      case (phase)
        PH_IDLE: begin
          ready_o <= ~start;
          if (start) begin
            hash_valid_o <= 1'b0;
            cnt          <= '0;
            phase        <= PH_LOAD;
          end
        end
        PH_LOAD: begin
          if (cnt < BLOCK_WORDS) begin
            cnt <= cnt + 7'd1;
          end else if (fifo_vld_i) begin   // last word lands a cycle after last pop
            cnt   <= '0;
            phase <= PH_ROUND;
          end
        end
        PH_ROUND: begin
          cnt <= cnt + 7'd1;
          if (cnt == ROUNDS-1)
            phase <= PH_ADD;
        end
        default: begin                     // add working state into the hash
          hash_o       <= hash_sum;
          hash_valid_o <= 1'b1;
          ready_o      <= 1'b1;
          phase        <= PH_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sha256/hash_capture.sv
`timescale 1ns/1ps
`default_nettype none

module hash_capture import regs_pkg::*; (
  input  logic  clk_125mhz,
  input  logic  rstn_i,
  input  logic  hash_valid_i,
  input  hash_t hash_i,
  output hash_t hash_words_o   // stable until the next block completes
);

  logic valid_q;               // for rising edge detect

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_i) begin
      valid_q      <= 1'b0;
      hash_words_o <= '0;      // reads 0 while held in reset
    end else begin
      valid_q <= hash_valid_i;
      if (hash_valid_i && !valid_q)
        hash_words_o <= hash_i;
    end
  end

endmodule

`default_nettype wire

// File: design/hash_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

module hash_regs_top import regs_pkg::*; (
  input  logic              clk_125mhz,
  input  logic              rstn_125mhz,
  input  logic [WORD_W-1:0] sys_addr_i,
  input  logic [WORD_W-1:0] sys_wdata_i,
  input  logic [3:0]        sys_sel_i,      // byte lanes ignored, whole word writes
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [WORD_W-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              x11_activated_o
);

  logic                  sha_rstn;          // reset of the whole sha-256 part
  logic                  push;
  logic [WORD_W-1:0]     push_data;
  logic                  pop;
  logic [WORD_W-1:0]     fifo_data;
  logic                  fifo_vld;
  logic [FIFO_CNT_W-1:0] fifo_count;
  logic                  fifo_empty;
  logic                  fifo_afull;
  logic                  fifo_full;
  logic                  sha_ready;
  logic                  sha_valid;
  hash_t                 hash_chain;        // live chaining value
  hash_t                 hash_words;        // captured copy for the bus

  bus_regs i_bus_regs (
    .clk_125mhz      (clk_125mhz),
    .rstn_125mhz     (rstn_125mhz),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_wen_i       (sys_wen_i),
    .sys_ren_i       (sys_ren_i),
    .fifo_count_i    (fifo_count),
    .fifo_empty_i    (fifo_empty),
    .fifo_afull_i    (fifo_afull),
    .fifo_full_i     (fifo_full),
    .sha_ready_i     (sha_ready),
    .sha_valid_i     (sha_valid),
    .hash_words_i    (hash_words),
    .sys_rdata_o     (sys_rdata_o),
    .sys_ack_o       (sys_ack_o),
    .x11_activated_o (x11_activated_o),
    .sha_rstn_o      (sha_rstn),
    .push_o          (push),
    .push_data_o     (push_data)
  );

  word_fifo i_word_fifo (
    .clk_125mhz  (clk_125mhz),
    .rstn_i      (sha_rstn),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .rd_data_o   (fifo_data),
    .rd_vld_o    (fifo_vld),
    .count_o     (fifo_count),
    .empty_o     (fifo_empty),
    .afull_o     (fifo_afull),
    .full_o      (fifo_full)
  );

  sha256_engine i_sha256_engine (
    .clk_125mhz   (clk_125mhz),
    .rstn_i       (sha_rstn),
    .fifo_count_i (fifo_count),
    .fifo_data_i  (fifo_data),
    .fifo_vld_i   (fifo_vld),
    .fifo_pop_o   (pop),
    .ready_o      (sha_ready),
    .hash_valid_o (sha_valid),
    .hash_o       (hash_chain)
  );

  hash_capture i_hash_capture (
    .clk_125mhz   (clk_125mhz),
    .rstn_i       (sha_rstn),
    .hash_valid_i (sha_valid),
    .hash_i       (hash_chain),
    .hash_words_o (hash_words)
  );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_125mhz,
  output logic rstn_125mhz
);

  initial begin
    clk_125mhz = 1'b0;
    forever #4 clk_125mhz = ~clk_125mhz;  // 8 ns period
  end

  initial begin
    rstn_125mhz = 1'b0;
    repeat (8) @(posedge clk_125mhz);     // 8 cycles in reset
    rstn_125mhz <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/sha256_model.svh
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

// reference sha-256 compression, one 512 bit block, word 0 in the top bits

localparam hash_t model_iv = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                              32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

// padded "abc" and its digest, known answer
localparam logic [511:0] kat_block  = {32'h61626380, 448'h0, 32'h00000018};
localparam hash_t        kat_digest = {32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
                                       32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad};

function automatic logic [31:0] rot_right(input logic [31:0] x, input int n);
  return (x >> n) | (x << (32 - n));
endfunction

function automatic hash_t compress_block(input hash_t chain, input logic [511:0] blk);
  logic [31:0] w [0:63];
  logic [31:0] a, b, c, d, e, f, g, h;
  logic [31:0] s0, s1, t1, t2;
  hash_t       work;
  hash_t       res;
  for (int t = 0; t < 16; t++)
    w[t] = blk[511 - 32*t -: 32];
  for (int t = 16; t < 64; t++) begin     // message expansion
    s0   = rot_right(w[t-15], 7) ^ rot_right(w[t-15], 18) ^ (w[t-15] >> 3);
    s1   = rot_right(w[t-2], 17) ^ rot_right(w[t-2], 19) ^ (w[t-2] >> 10);
    w[t] = w[t-16] + s0 + w[t-7] + s1;
  end
  {a, b, c, d, e, f, g, h} = chain;
  for (int t = 0; t < 64; t++) begin
    s1 = rot_right(e, 6) ^ rot_right(e, 11) ^ rot_right(e, 25);
    t1 = h + s1 + ((e & f) ^ (~e & g)) + sha_k[t] + w[t];
    s0 = rot_right(a, 2) ^ rot_right(a, 13) ^ rot_right(a, 22);
    t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
    h  = g;
    g  = f;
    f  = e;
    e  = d + t1;
    d  = c;
    c  = b;
    b  = a;
    a  = t1 + t2;
  end
  work = {a, b, c, d, e, f, g, h};
  for (int i = 0; i < 8; i++)              // feed forward
    res[i*32 +: 32] = chain[i*32 +: 32] + work[i*32 +: 32];
  return res;
endfunction

`endif

// File: tests/tb_hash_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hash_regs import regs_pkg::*;;

  logic        clk_125mhz;
  logic        rstn_125mhz;
  logic [31:0] sys_addr;
  logic [31:0] sys_wdata;
  logic [3:0]  sys_sel;
  logic        sys_wen;
  logic        sys_ren;
  logic [31:0] sys_rdata;
  logic        sys_ack;
  logic        x11_activated;
  integer      seed;                      // $random state

  `include "sha256_model.svh"

  tb_clk_gen i_tb_clk_gen (
    .clk_125mhz  (clk_125mhz),
    .rstn_125mhz (rstn_125mhz)
  );

  hash_regs_top hash_regs_top_i (
    .clk_125mhz      (clk_125mhz),
    .rstn_125mhz     (rstn_125mhz),
    .sys_addr_i      (sys_addr),
    .sys_wdata_i     (sys_wdata),
    .sys_sel_i       (sys_sel),
    .sys_wen_i       (sys_wen),
    .sys_ren_i       (sys_ren),
    .sys_rdata_o     (sys_rdata),
    .sys_ack_o       (sys_ack),
    .x11_activated_o (x11_activated)
  );

  // ------------------------------------------------------------
  // error exits
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    stop_run($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  // ------------------------------------------------------------
  // bus access with a one cycle strobe and the ack one cycle later
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_125mhz);
    sys_addr  <= addr;
    sys_wdata <= data;
    sys_wen   <= 1'b1;
    @(negedge clk_125mhz);
    assert (sys_ack === 1'b0) else stop_run("ack seen before the write strobe was sampled");
    @(posedge clk_125mhz);
    sys_wen <= 1'b0;
    @(negedge clk_125mhz);
    assert (sys_ack === 1'b1) else stop_run("no ack one cycle after the write strobe");
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_125mhz);
    sys_addr <= addr;
    sys_ren  <= 1'b1;
    @(negedge clk_125mhz);
    assert (sys_ack === 1'b0) else stop_run("ack seen before the read strobe was sampled");
    @(posedge clk_125mhz);
    sys_ren <= 1'b0;
    @(negedge clk_125mhz);
    assert (sys_ack === 1'b1) else stop_run("no ack one cycle after the read strobe");
    data = sys_rdata;                     // stable half a cycle after the edge
  endtask

  task automatic check_read(input logic [31:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    bus_read(addr, got);
    assert (got === exp) else fail_value($sformatf("sys_rdata_o %s", name), got, exp);
  endtask

  // H7 sits at the low address, so word i of the window is bits i*32 of hash_t
  task automatic check_hash(input hash_t exp);
    logic [31:0] got;
    for (int i = 0; i < HASH_WORDS; i++) begin
      bus_read(32'(ADR_SHA_HASH_H7) + 32'(4*i), got);
      assert (got === exp[i*WORD_W +: WORD_W])
        else fail_value($sformatf("sys_rdata_o H%0d", 7 - i), got, exp[i*WORD_W +: WORD_W]);
    end
  endtask

  // ------------------------------------------------------------
  // stimulus helpers
  task automatic make_block(output logic [511:0] blk);
    for (int t = 0; t < BLOCK_WORDS; t++)
      blk[511 - 32*t -: 32] = $random(seed);
  endtask

  task automatic push_words(input logic [511:0] blk, input int first, input int last);
    for (int t = first; t < last; t++)
      bus_write(32'(ADR_SHA_PUSH), blk[511 - 32*t -: 32]);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_125mhz);
  endtask

  // valid may still show the previous block, so see it drop first
  task automatic wait_block_done();
    logic [31:0] st;
    int          polls;
    polls = 0;
    bus_read(32'(ADR_SHA_STATUS), st);
    while (st[SHA_ST_VALID]) begin
      polls = polls + 1;
      if (polls > 20)
        stop_run("hash valid never dropped after a full block was pushed");
      bus_read(32'(ADR_SHA_STATUS), st);
    end
    polls = 0;
    while (!st[SHA_ST_VALID]) begin
      polls = polls + 1;
      if (polls > 200)
        stop_run("timed out waiting for hash valid");
      bus_read(32'(ADR_SHA_STATUS), st);
    end
  endtask

  initial begin
    repeat (50000) @(posedge clk_125mhz);
    stop_run("simulation watchdog expired");
  end

  // ------------------------------------------------------------
  // main sequence
  initial begin
    int           n;
    hash_t        chain;
    hash_t        exp;
    logic [511:0] blk;
    seed      = 32'hade014af;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_sel   = 4'hf;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    assert (compress_block(model_iv, kat_block) === kat_digest)
      else stop_run("reference model fails the abc known answer");

    n = 0;
    while (rstn_125mhz !== 1'b1) begin
      @(posedge clk_125mhz);
      n = n + 1;
      if (n > 50)
        stop_run("reset was never released");
    end

    // after reset
    check_read(32'(ADR_CTRL), 32'h0, "ctrl");
    check_read(32'(ADR_STATUS), 32'h0, "status");
    check_read(32'(ADR_SHA_CTRL), 32'h0, "sha ctrl");
    check_read(32'(ADR_SHA_STATUS), 32'h0, "sha status");  // empty hidden while inactive
    check_read(32'(ADR_VERSION), CURRENT_DATE, "version");
    check_read(32'h0000_0200, 32'h0, "unmapped 0x200");
    check_read(32'(ADR_SHA_FILL), 32'h0, "fill");
    check_hash('0);

    // control and activation
    bus_write(32'(ADR_CTRL), 32'h1 << CTRL_ENABLE);
    check_read(32'(ADR_CTRL), 32'h1 << CTRL_ENABLE, "ctrl");
    check_read(32'(ADR_STATUS), 32'h1 << STAT_X11_ACT, "status");  // sha still off
    assert (x11_activated === 1'b1) else fail_value("x11_activated_o", 32'(x11_activated), 32'h1);
    bus_write(32'(ADR_SHA_CTRL), (32'h1 << SHA_CTRL_ENABLE) | (32'h1 << SHA_CTRL_RESET));
    check_read(32'(ADR_SHA_CTRL), 32'h1 << SHA_CTRL_ENABLE, "sha ctrl");
    check_read(32'(ADR_STATUS), (32'h1 << STAT_X11_ACT) | (32'h1 << STAT_SHA_ACT), "status");
    check_read(32'(ADR_SHA_STATUS), (32'h1 << SHA_ST_READY) | (32'h1 << SHA_ST_EMPTY),
               "sha status");

    // partial fill gives no start below 16 words
    make_block(blk);
    push_words(blk, 0, 5);
    check_read(32'(ADR_SHA_FILL), 32'd5, "fill");
    check_read(32'(ADR_SHA_STATUS), 32'h1 << SHA_ST_READY, "sha status");

    // first block from the iv
    push_words(blk, 5, BLOCK_WORDS);
    wait_block_done();
    exp = compress_block(model_iv, blk);
    check_hash(exp);
    check_read(32'(ADR_SHA_FILL), 32'h0, "fill");
    chain = exp;

    // second block chains
    make_block(blk);
    push_words(blk, 0, BLOCK_WORDS);
    wait_block_done();
    check_hash(compress_block(chain, blk));

    // one-shot reset clears the hash words
    bus_write(32'(ADR_SHA_CTRL), (32'h1 << SHA_CTRL_ENABLE) | (32'h1 << SHA_CTRL_RESET));
    idle_cycles(2);                       // registered reset reaches the sha part
    check_hash('0);
    check_read(32'(ADR_SHA_CTRL), 32'h1 << SHA_CTRL_ENABLE, "sha ctrl");

    // back to the iv
    make_block(blk);
    push_words(blk, 0, BLOCK_WORDS);
    wait_block_done();
    check_hash(compress_block(model_iv, blk));

    // global disable
    bus_write(32'(ADR_CTRL), 32'h0);
    check_read(32'(ADR_STATUS), 32'h0, "status");
    assert (x11_activated === 1'b0) else fail_value("x11_activated_o", 32'(x11_activated), 32'h0);
    check_hash('0);
    bus_write(32'(ADR_SHA_PUSH), $random(seed));
    check_read(32'(ADR_SHA_FILL), 32'h0, "fill");  // fifo held in reset
    check_read(32'(ADR_SHA_STATUS), 32'h0, "sha status");

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+tests
common/regs_pkg.sv
design/bus_regs.sv
sha256/word_fifo.sv
sha256/sha256_sched.sv
sha256/sha256_engine.sv
sha256/hash_capture.sv
design/hash_regs_top.sv
tests/tb_clk_gen.sv
tests/tb_hash_regs.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_hash_regs -o tb_hash_regs &&
./obj_dir/tb_hash_regs ||
{ echo "simulation run failed"; exit 1; }
